// ==== include/div_consts.svh ====
// ----------------------------------------------------------
// divide unit constants
// operand width, lane count and steps per division
// ----------------------------------------------------------
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand width in bits
`define DIV_XLEN 32

// number of divider lanes, served round-robin
`define DIV_LANES 4

// one quotient bit per step
`define DIV_ITERS `DIV_XLEN

`endif

// ==== src/div_msg_pkg.sv ====
// ----------------------------------------------------------
// divide request and response types
// opcode, operand word and the packed result word
// ----------------------------------------------------------
`include "div_consts.svh"

package div_msg_pkg;

  // divide opcode, signed or unsigned
  typedef enum logic {
    op_divu = 1'b0,
    op_div  = 1'b1
  } div_op_t;

  // operand word on the request side
  typedef logic [`DIV_XLEN-1:0] div_word_t;

  // response word
  // remainder in the upper half, quotient in the lower half
  typedef struct packed {
    div_word_t rem;
    div_word_t quo;
  } div_result_t;

endpackage

// ==== src/div_ctrl_pkg.sv ====
// ----------------------------------------------------------
// divide lane control types
// ----------------------------------------------------------

package div_ctrl_pkg;

  // lane state machine
  // idle waits for a request, calc runs load plus the steps,
  // fix applies signs, done holds the result for the collector
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_fix  = 2'd2,
    st_done = 2'd3
  } lane_state_t;

endpackage

// ==== src/div_dispatch.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// round-robin request dispatcher
// steers each request to the lane under the issue pointer
// ----------------------------------------------------------
`include "div_consts.svh"

module div_dispatch (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic lane_req_val [`DIV_LANES],
  input  logic lane_req_rdy [`DIV_LANES]
);

  // issue pointer, lane that gets the next request
  logic [$clog2(`DIV_LANES)-1:0] ptr;
  logic issue;

  // only the pointed lane may take a request
  // a busy lane here blocks issue even if others are idle,
  // which keeps responses in request order
  assign req_rdy = lane_req_rdy[ptr];
  assign issue   = req_val && req_rdy;

  // decode pointer into per-lane val
  always_comb begin
    for (int i = 0; i < `DIV_LANES; i++) begin
      lane_req_val[i] = req_val && (int'(ptr) == i);
    end
  end

  // advance on every accepted request, wrap at the last lane
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (issue) begin
      if (int'(ptr) == `DIV_LANES - 1) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // an offered request stays up until a lane takes it
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val);

endmodule

// ==== src/div_lane.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// iterative divider lane
// restoring shift-subtract, signed or unsigned, 34 cycles
// ----------------------------------------------------------
`include "div_consts.svh"

module div_lane (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     lane_req_val,
  output logic                     lane_req_rdy,
  input  div_msg_pkg::div_op_t     op,
  input  div_msg_pkg::div_word_t   a,
  input  div_msg_pkg::div_word_t   b,
  output logic                     lane_resp_val,
  input  logic                     lane_resp_rdy,
  output div_msg_pkg::div_result_t result
);

  import div_msg_pkg::*;
  import div_ctrl_pkg::*;

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------

  lane_state_t state;
  // count 0 is the load step, 1 to DIV_ITERS are the divide steps
  logic [$clog2(`DIV_ITERS + 1)-1:0] count;

  logic accept;
  logic send;
  logic load_step;
  logic calc_step;

  assign lane_req_rdy  = (state == st_idle);
  assign lane_resp_val = (state == st_done);
  assign accept        = lane_req_val && lane_req_rdy;
  assign send          = lane_resp_val && lane_resp_rdy;
  assign load_step     = (state == st_calc) && (count == '0);
  assign calc_step     = (state == st_calc) && (count != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // leave after the last divide step
          if (int'(count) == `DIV_ITERS) begin
            state <= st_fix;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // hold the result until the collector takes it
          if (send) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  // request payload, captured on the accepting edge
  div_op_t   op_q;
  div_word_t a_q;
  div_word_t b_q;

  // operand signs, only meaningful for op_div
  logic sign_a;
  logic sign_b;

  // remainder/quotient pair and divisor aligned to the upper half
  logic [2*`DIV_XLEN:0] rq;
  logic [2*`DIV_XLEN:0] dvsr;

  logic                 neg_a;
  logic                 neg_b;
  div_word_t            mag_a;
  div_word_t            mag_b;
  logic [2*`DIV_XLEN:0] rq_shift;
  logic [2*`DIV_XLEN:0] rq_diff;
  div_word_t            quo_mag;
  div_word_t            rem_mag;

  assign neg_a = (op_q == op_div) && a_q[`DIV_XLEN-1];
  assign neg_b = (op_q == op_div) && b_q[`DIV_XLEN-1];
  assign mag_a = neg_a ? -a_q : a_q;
  assign mag_b = neg_b ? -b_q : b_q;

  // one restoring step, msb of the difference set means it went negative
  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - dvsr;

  assign quo_mag = rq[`DIV_XLEN-1:0];
  assign rem_mag = rq[2*`DIV_XLEN-1:`DIV_XLEN];

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= op;
      a_q  <= a;
      b_q  <= b;
    end
    if (load_step) begin
      sign_a <= neg_a;
      sign_b <= neg_b;
      rq     <= {{(`DIV_XLEN + 1){1'b0}}, mag_a};
      dvsr   <= {1'b0, mag_b, {`DIV_XLEN{1'b0}}};
    end else if (calc_step) begin
      // keep the difference and shift in a 1 when it stays positive
      if (rq_diff[2*`DIV_XLEN]) begin
        rq <= rq_shift;
      end else begin
        rq <= {rq_diff[2*`DIV_XLEN:1], 1'b1};
      end
    end
    if (state == st_fix) begin
      if (b_q == '0) begin
        // divide by zero, all-ones quotient and dividend as remainder
        result.quo <= '1;
        result.rem <= a_q;
      end else begin
        // quotient truncates toward zero, remainder follows dividend
        result.quo <= (sign_a ^ sign_b) ? -quo_mag : quo_mag;
        result.rem <= sign_a ? -rem_mag : rem_mag;
      end
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // no new request is taken while a division is in flight
  a_busy: assert property (@(posedge clk) disable iff (reset)
    accept |=> !lane_req_rdy [*(`DIV_ITERS + 3)]);

  // response shows up exactly 34 cycles after the accepting edge
  a_latency: assert property (@(posedge clk) disable iff (reset)
    accept |=> !lane_resp_val [*(`DIV_ITERS + 2)] ##1 lane_resp_val);

  a_hold: assert property (@(posedge clk) disable iff (reset)
    lane_resp_val && !lane_resp_rdy |=> lane_resp_val && $stable(result));

endmodule

// ==== src/div_collect.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// in-order response collector
// drains the lanes round-robin, same order as the dispatcher
// ----------------------------------------------------------
`include "div_consts.svh"

module div_collect (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     lane_resp_val    [`DIV_LANES],
  input  div_msg_pkg::div_result_t lane_resp_result [`DIV_LANES],
  output logic                     lane_resp_rdy    [`DIV_LANES],
  output logic                     resp_val,
  output div_msg_pkg::div_result_t resp_result,
  input  logic                     resp_rdy
);

  // drain pointer, lane whose result goes out next
  logic [$clog2(`DIV_LANES)-1:0] ptr;
  logic drain;

  // present the pointed lane only
  // a finished lane elsewhere waits for its turn
  assign resp_val    = lane_resp_val[ptr];
  assign resp_result = lane_resp_result[ptr];
  assign drain       = resp_val && resp_rdy;

  // route the output rdy back to the pointed lane
  always_comb begin
    for (int i = 0; i < `DIV_LANES; i++) begin
      lane_resp_rdy[i] = resp_rdy && (int'(ptr) == i);
    end
  end

  // advance on every transfer out, wrap at the last lane
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (drain) begin
      if (int'(ptr) == `DIV_LANES - 1) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // a stalled response must not change under the consumer
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result));

endmodule

// ==== src/div_array.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// multi-lane divide unit top
// dispatcher, round-robin divider lanes and in-order collector
// ----------------------------------------------------------
`include "div_consts.svh"

module div_array (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  div_msg_pkg::div_op_t     req_op,
  input  div_msg_pkg::div_word_t   req_a,
  input  div_msg_pkg::div_word_t   req_b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output div_msg_pkg::div_result_t resp_result
);

  import div_msg_pkg::*;

  // dispatcher to lanes, payload buses are shared
  logic        lane_req_val     [`DIV_LANES];
  logic        lane_req_rdy     [`DIV_LANES];
  // lanes to collector
  logic        lane_resp_val    [`DIV_LANES];
  logic        lane_resp_rdy    [`DIV_LANES];
  div_result_t lane_resp_result [`DIV_LANES];

  div_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk           (clk),
      .reset         (reset),
      .lane_req_val  (lane_req_val[i]),
      .lane_req_rdy  (lane_req_rdy[i]),
      .op            (req_op),
      .a             (req_a),
      .b             (req_b),
      .lane_resp_val (lane_resp_val[i]),
      .lane_resp_rdy (lane_resp_rdy[i]),
      .result        (lane_resp_result[i])
    );
  end

  div_collect u_collect (
    .clk              (clk),
    .reset            (reset),
    .lane_resp_val    (lane_resp_val),
    .lane_resp_result (lane_resp_result),
    .lane_resp_rdy    (lane_resp_rdy),
    .resp_val         (resp_val),
    .resp_result      (resp_result),
    .resp_rdy         (resp_rdy)
  );

endmodule

// ==== test/div_checker.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// response checker for the divide unit
// compares each result against the queued expectations
// ----------------------------------------------------------
`include "div_consts.svh"

module div_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input div_msg_pkg::div_result_t resp_result
);

  import div_msg_pkg::*;

  // expectations in request order
  string       name_q [$];
  div_result_t want_q [$];

  int mismatches = 0;
  int unexpected = 0;
  int checked    = 0;

  // called by the driver on the accepting edge of a request
  task automatic push_expect(input string name, input div_result_t want);
    name_q.push_back(name);
    want_q.push_back(want);
  endtask

  // responses still owed by the DUT
  function automatic int pending();
    return want_q.size();
  endfunction

  // ----------------------------------------------------------
  // compare on every transfer out of the DUT
  // ----------------------------------------------------------
  always @(posedge clk) begin
    string       name;
    div_result_t want;
    if (!reset && resp_val && resp_rdy) begin
      if (want_q.size() == 0) begin
        // extra or duplicated response
        unexpected++;
        $display("a response %h came out with no request outstanding", resp_result);
      end else begin
        name = name_q.pop_front();
        want = want_q.pop_front();
        checked++;
        if (resp_result !== want) begin
          mismatches++;
          $display("ERR %s: expected rem=%h quo=%h actual rem=%h quo=%h",
                   name, want.rem, want.quo, resp_result.rem, resp_result.quo);
        end
      end
    end
  end

endmodule

// ==== test/div_array_tb.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------
// testbench for the multi-lane divide unit
// table driven requests, random rows, back-pressure on resp
// ----------------------------------------------------------
`include "div_consts.svh"

module div_array_tb;

  import div_msg_pkg::*;

  localparam int REQ_TIMEOUT   = 2000;
  localparam int DRAIN_TIMEOUT = 4000;
  // cycles from the accepting edge to resp_val on an idle unit
  localparam int LATENCY       = `DIV_ITERS + 2;

  logic        clk      = 1'b0;
  logic        reset    = 1'b1;
  logic        req_val  = 1'b0;
  logic        req_rdy;
  div_op_t     req_op   = op_divu;
  div_word_t   req_a    = '0;
  div_word_t   req_b    = '0;
  logic        resp_val;
  logic        resp_rdy = 1'b0;
  div_result_t resp_result;

  // stimulus table, one entry per row in every queue
  string       t_name  [$];
  div_op_t     t_op    [$];
  div_word_t   t_a     [$];
  div_word_t   t_b     [$];
  div_word_t   t_quo   [$];
  div_word_t   t_rem   [$];
  logic [15:0] t_stall [$];

  // resp_rdy pattern of the last accepted row, one bit per cycle
  logic [15:0] rdy_mask  = 16'hffff;
  logic [3:0]  rdy_phase = 4'd0;
  int          other_errs = 0;
  int          bp_stalls  = 0;
  bit          timed_out  = 1'b0;

  // 40 ns clock
  always #20 clk = ~clk;

  div_array i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  div_checker u_check (
    .clk         (clk),
    .reset       (reset),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // consumer side, 2 ns after the edge like the request side
  always @(posedge clk) begin
    #2;
    rdy_phase = rdy_phase + 4'd1;
    resp_rdy  = rdy_mask[rdy_phase];
  end

  task automatic add_row(input string name, input div_op_t op, input div_word_t a,
                         input div_word_t b, input div_word_t quo, input div_word_t rem,
                         input logic [15:0] stall);
    t_name.push_back(name);
    t_op.push_back(op);
    t_a.push_back(a);
    t_b.push_back(b);
    t_quo.push_back(quo);
    t_rem.push_back(rem);
    t_stall.push_back(stall);
  endtask

  // division rules, truncation toward zero, defined corner results
  function automatic div_result_t expect_div(input div_op_t op, input div_word_t a,
                                             input div_word_t b);
    div_result_t r;
    if (b == '0) begin
      r.quo = '1;
      r.rem = a;
    end else if (op == op_div && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      r.quo = a;
      r.rem = '0;
    end else if (op == op_div) begin
      r.quo = $signed(a) / $signed(b);
      r.rem = $signed(a) % $signed(b);
    end else begin
      r.quo = a / b;
      r.rem = a % b;
    end
    return r;
  endfunction

  task automatic build_table();
    div_op_t     op;
    div_word_t   a;
    div_word_t   b;
    div_result_t want;
    logic [15:0] stall;
    // directed rows, lane fill with an always ready consumer
    add_row("divu_small",  op_divu, 32'd100,       32'd7,         32'd14,        32'd2,        16'hffff);
    add_row("divu_less",   op_divu, 32'd5,         32'd9,         32'd0,         32'd5,        16'hffff);
    add_row("divu_large",  op_divu, 32'hffff_ffff, 32'h10,        32'h0fff_ffff, 32'hf,        16'hffff);
    add_row("divu_msb",    op_divu, 32'h8000_0000, 32'd3,         32'h2aaa_aaaa, 32'd2,        16'hffff);
    add_row("div_pp",      op_div,  32'd17,        32'd5,         32'd3,         32'd2,        16'hffff);
    add_row("div_np",      op_div,  32'hffff_ffef, 32'd5,         32'hffff_fffd, 32'hffff_fffe, 16'hffff);
    add_row("div_pn",      op_div,  32'd17,        32'hffff_fffb, 32'hffff_fffd, 32'd2,        16'hffff);
    add_row("div_nn",      op_div,  32'hffff_ffef, 32'hffff_fffb, 32'd3,         32'hffff_fffe, 16'hffff);
    add_row("divu_zero",   op_divu, 32'h1234,      32'd0,         32'hffff_ffff, 32'h1234,     16'hffff);
    add_row("div_zero",    op_div,  32'hffff_fff0, 32'd0,         32'hffff_ffff, 32'hffff_fff0, 16'hffff);
    add_row("div_ovf",     op_div,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'd0,        16'hffff);
    add_row("divu_ones",   op_divu, 32'h8000_0000, 32'hffff_ffff, 32'd0,         32'h8000_0000, 16'hffff);
    // back-pressure, consumer ready one cycle in sixteen
    add_row("bp_0",        op_divu, 32'h3e8,       32'ha,         32'h64,        32'd0,        16'h0001);
    add_row("bp_1",        op_divu, 32'hdead_beef, 32'd1,         32'hdead_beef, 32'd0,        16'h0001);
    add_row("bp_2",        op_divu, 32'hdead_beef, 32'hdead_beef, 32'd1,         32'd0,        16'h0001);
    add_row("bp_3",        op_divu, 32'hff,        32'h10,        32'hf,         32'hf,        16'h0001);
    add_row("bp_4",        op_div,  32'hffff_ff9c, 32'd7,         32'hffff_fff2, 32'hffff_fffe, 16'h0001);
    add_row("bp_5",        op_div,  32'd7,         32'hffff_ff9c, 32'd0,         32'd7,        16'h0001);
    // random rows, small divisors and zero now and then
    for (int i = 0; i < 40; i++) begin
      op    = ($urandom % 2 == 0) ? op_divu : op_div;
      a     = $urandom;
      b     = ($urandom % 4 == 0) ? ($urandom % 8) : $urandom;
      want  = expect_div(op, a, b);
      stall = ($urandom % 2 == 0) ? 16'hffff : (16'($urandom) | 16'h0101);
      add_row($sformatf("rand_%0d", i), op, a, b, want.quo, want.rem, stall);
    end
  endtask

  // entered at a drive point, returns at the next one after acceptance
  task automatic send_request(input int idx);
    int          waited;
    div_result_t want;
    waited   = 0;
    want.quo = t_quo[idx];
    want.rem = t_rem[idx];
    req_val  = 1'b1;
    req_op   = t_op[idx];
    req_a    = t_a[idx];
    req_b    = t_b[idx];
    // inputs hold until the edge, so req_rdy at negedge decides the transfer
    @(negedge clk);
    while (!req_rdy && waited < REQ_TIMEOUT) begin
      if (rdy_mask != 16'hffff) begin
        bp_stalls++;
      end
      waited++;
      @(negedge clk);
    end
    if (!req_rdy) begin
      $display("timeout: request %s was never accepted", t_name[idx]);
      other_errs++;
      timed_out = 1'b1;
    end else begin
      u_check.push_expect(t_name[idx], want);
      rdy_mask = t_stall[idx];
    end
    @(posedge clk);
    #2;
  endtask

  // lone request on idle lanes, count edges until resp_val
  task automatic check_latency();
    int cycles;
    req_val = 1'b0;
    cycles  = 0;
    @(negedge clk);
    while (!resp_val && cycles < LATENCY + 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!resp_val) begin
      $display("timeout: the first response never showed up");
      other_errs++;
    end else if (cycles != LATENCY) begin
      $display("ERR latency: expected %0d actual %0d", LATENCY, cycles);
      other_errs++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic check_idle_after_reset();
    repeat (3) begin
      @(negedge clk);
      if (resp_val !== 1'b0 || req_rdy !== 1'b1) begin
        $display("after reset the unit was not idle, resp_val %b req_rdy %b",
                 resp_val, req_rdy);
        other_errs++;
      end
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited   = 0;
    req_val  = 1'b0;
    rdy_mask = 16'hffff;
    while (u_check.pending() > 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (u_check.pending() > 0) begin
      $display("timeout: %0d responses never came back", u_check.pending());
      other_errs++;
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    int seed;
    int total;
    seed = $urandom(32'hafd828cd);
    build_table();
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    check_idle_after_reset();
    @(posedge clk);
    #2;
    for (int i = 0; i < t_name.size(); i++) begin
      send_request(i);
      if (timed_out) begin
        break;
      end
      if (i == 0) begin
        check_latency();
      end
    end
    if (!timed_out) begin
      drain_responses();
    end
    if (bp_stalls == 0) begin
      $display("req_rdy never dropped while the consumer was stalling");
      other_errs++;
    end
    total = u_check.mismatches + u_check.unexpected + other_errs;
    $display("checked %0d, mismatches %0d, unexpected %0d, other errors %0d",
             u_check.checked, u_check.mismatches, u_check.unexpected, other_errs);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/div_msg_pkg.sv
src/div_ctrl_pkg.sv
src/div_dispatch.sv
src/div_lane.sv
src/div_collect.sv
src/div_array.sv
test/div_checker.sv
test/div_array_tb.sv

// ==== Makefile ====
# Verilator build and run for the divide unit testbench

SIM = obj_dir/Vdiv_array_tb

$(SIM): src.f include/div_consts.svh $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module div_array_tb -o Vdiv_array_tb

run: $(SIM)
	./$(SIM) > sim.log
	cat sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
